// ==== fe_pc_gen.f ====
logic/fe_pkg.sv
logic/fe_btb.sv
logic/fe_bht.sv
logic/fe_pc_select.sv
logic/fe_pc_gen.sv
verif/tb_fe_pc_gen.sv

// ==== logic/fe_bht.sv ====
// Gshare branch history table
`timescale 1ns/1ps
`default_nettype none

module fe_bht (
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire            r_v_i,
  input  fe_pkg::vaddr_t r_addr_i,
  input  fe_pkg::ghist_t r_ghist_i,
  input  wire            w_v_i,
  input  fe_pkg::vaddr_t w_addr_i,
  input  fe_pkg::ghist_t w_ghist_i,
  input  wire            w_taken_i,
  output logic           pred_o,
  output logic           init_done_o
);

  fe_pkg::ctr_t ctr_mem [fe_pkg::bht_entries];

  fe_pkg::init_state_e state_r;
  fe_pkg::bht_idx_t    init_cnt_r;

  fe_pkg::bht_idx_t r_idx;
  fe_pkg::bht_idx_t w_idx;

  // Top index bits are folded with the global history
  function automatic fe_pkg::bht_idx_t hash_idx(input fe_pkg::vaddr_t addr,
                                                 input fe_pkg::ghist_t ghist);
    fe_pkg::bht_idx_t idx;
    idx = addr[fe_pkg::start_bit +: fe_pkg::bht_idx_width];
    idx[fe_pkg::bht_idx_width-1 -: fe_pkg::ghist_width] =
      idx[fe_pkg::bht_idx_width-1 -: fe_pkg::ghist_width] ^ ghist;
    return idx;
  endfunction

  // One saturating step toward the outcome
  function automatic fe_pkg::ctr_t ctr_step(input fe_pkg::ctr_t ctr, input logic taken);
    fe_pkg::ctr_t nxt;
    nxt = ctr;
    if (taken && (ctr != 2'b11))
      nxt = ctr + 1'b1;
    else if (!taken && (ctr != 2'b00))
      nxt = ctr - 1'b1;
    return nxt;
  endfunction

  assign r_idx       = hash_idx(r_addr_i, r_ghist_i);
  assign w_idx       = hash_idx(w_addr_i, w_ghist_i);
  assign init_done_o = (state_r == fe_pkg::init_ready);

  //////////////////////////////////////////////////
  // Reset sweep and counter update
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r    <= fe_pkg::init_sweep;
      init_cnt_r <= '0;
    end
    else if (state_r == fe_pkg::init_sweep)
    begin
      init_cnt_r <= init_cnt_r + 1'b1;
      if (init_cnt_r == fe_pkg::bht_idx_t'(fe_pkg::bht_entries - 1))
        state_r <= fe_pkg::init_ready;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_r == fe_pkg::init_sweep)
      ctr_mem[init_cnt_r] <= fe_pkg::ctr_weak_nt;
    else if (w_v_i)
      ctr_mem[w_idx] <= ctr_step(ctr_mem[w_idx], w_taken_i);
  end

  // Registered prediction, counter msb
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pred_o <= 1'b0;
    else if (r_v_i)
      pred_o <= init_done_o && ctr_mem[r_idx][1];
  end

  a_no_write_in_sweep: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_v_i |-> init_done_o);

endmodule

`default_nettype wire

// ==== logic/fe_btb.sv ====
// Branch target buffer
`timescale 1ns/1ps
`default_nettype none

module fe_btb (
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire            r_v_i,
  input  fe_pkg::vaddr_t r_addr_i,
  input  wire            w_v_i,
  input  wire            w_clr_i,
  input  fe_pkg::vaddr_t w_addr_i,
  input  fe_pkg::vaddr_t w_tgt_i,
  output logic           hit_o,
  output fe_pkg::vaddr_t tgt_o,
  output logic           init_done_o
);

  logic             valid_r [fe_pkg::btb_entries];
  fe_pkg::btb_tag_t tag_mem [fe_pkg::btb_entries];
  fe_pkg::vaddr_t   tgt_mem [fe_pkg::btb_entries];

  fe_pkg::init_state_e state_r;
  fe_pkg::btb_idx_t    init_cnt_r;

  fe_pkg::btb_idx_t r_idx;
  fe_pkg::btb_tag_t r_tag;
  fe_pkg::btb_idx_t w_idx;
  fe_pkg::btb_tag_t w_tag;

  assign r_idx = r_addr_i[fe_pkg::start_bit +: fe_pkg::btb_idx_width];
  assign r_tag = r_addr_i[fe_pkg::start_bit + fe_pkg::btb_idx_width +: fe_pkg::btb_tag_width];
  assign w_idx = w_addr_i[fe_pkg::start_bit +: fe_pkg::btb_idx_width];
  assign w_tag = w_addr_i[fe_pkg::start_bit + fe_pkg::btb_idx_width +: fe_pkg::btb_tag_width];

  assign init_done_o = (state_r == fe_pkg::init_ready);

  //////////////////////////////////////////////////
  // Reset sweep
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r    <= fe_pkg::init_sweep;
      init_cnt_r <= '0;
    end
    else if (state_r == fe_pkg::init_sweep)
    begin
      init_cnt_r <= init_cnt_r + 1'b1;
      if (init_cnt_r == fe_pkg::btb_idx_t'(fe_pkg::btb_entries - 1))
        state_r <= fe_pkg::init_ready;
    end
  end

  // Sweep clears valid bits, then training owns the array
  always_ff @(posedge clk_i)
  begin
    if (state_r == fe_pkg::init_sweep)
      valid_r[init_cnt_r] <= 1'b0;
    else if (w_v_i)
    begin
      valid_r[w_idx] <= !w_clr_i;
      if (!w_clr_i)
      begin
        tag_mem[w_idx] <= w_tag;
        tgt_mem[w_idx] <= w_tgt_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Registered lookup
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      hit_o <= 1'b0;
    else if (r_v_i)
      hit_o <= init_done_o && valid_r[r_idx] && (tag_mem[r_idx] == r_tag);
  end

  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
      tgt_o <= tgt_mem[r_idx];
  end

  // Selector holds off training until both tables finish sweeping
  a_no_write_in_sweep: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_v_i |-> init_done_o);

  a_clr_needs_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_clr_i |-> w_v_i);

endmodule

`default_nettype wire

// ==== logic/fe_pc_gen.sv ====
// Fetch next-PC generator
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen (
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire            redirect_v_i,
  input  fe_pkg::vaddr_t redirect_pc_i,
  input  wire            redirect_br_v_i,
  input  fe_pkg::vaddr_t redirect_br_pc_i,
  input  wire            redirect_br_taken_i,
  input  fe_pkg::ghist_t redirect_br_ghist_i,
  input  wire            attaboy_v_i,
  input  fe_pkg::vaddr_t attaboy_pc_i,
  input  fe_pkg::vaddr_t attaboy_tgt_i,
  input  wire            attaboy_taken_i,
  input  fe_pkg::ghist_t attaboy_ghist_i,
  input  wire            if1_we_i,
  input  wire            if2_we_i,
  output fe_pkg::vaddr_t next_pc_o,
  output fe_pkg::vaddr_t if2_pc_o,
  output logic           if2_pred_taken_o,
  output fe_pkg::ghist_t if2_ghist_o,
  output logic           attaboy_yumi_o,
  output logic           init_done_o
);

  // Table read side
  logic           rd_v;
  fe_pkg::ghist_t rd_ghist;
  logic           btb_hit;
  fe_pkg::vaddr_t btb_tgt;
  logic           bht_pred;
  logic           btb_init_done;
  logic           bht_init_done;

  // Table write side
  logic           btb_w_v;
  logic           btb_w_clr;
  fe_pkg::vaddr_t btb_w_addr;
  fe_pkg::vaddr_t btb_w_tgt;
  logic           bht_w_v;
  fe_pkg::vaddr_t bht_w_addr;
  fe_pkg::ghist_t bht_w_ghist;
  logic           bht_w_taken;

  fe_btb btb (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .r_v_i(rd_v), .r_addr_i(next_pc_o),
    .w_v_i(btb_w_v), .w_clr_i(btb_w_clr), .w_addr_i(btb_w_addr), .w_tgt_i(btb_w_tgt),
    .hit_o(btb_hit), .tgt_o(btb_tgt), .init_done_o(btb_init_done)
  );

  fe_bht bht (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .r_v_i(rd_v), .r_addr_i(next_pc_o), .r_ghist_i(rd_ghist),
    .w_v_i(bht_w_v), .w_addr_i(bht_w_addr), .w_ghist_i(bht_w_ghist),
    .w_taken_i(bht_w_taken),
    .pred_o(bht_pred), .init_done_o(bht_init_done)
  );

  fe_pc_select pc_select (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .redirect_v_i(redirect_v_i), .redirect_pc_i(redirect_pc_i),
    .redirect_br_v_i(redirect_br_v_i), .redirect_br_pc_i(redirect_br_pc_i),
    .redirect_br_taken_i(redirect_br_taken_i), .redirect_br_ghist_i(redirect_br_ghist_i),
    .attaboy_v_i(attaboy_v_i), .attaboy_pc_i(attaboy_pc_i), .attaboy_tgt_i(attaboy_tgt_i),
    .attaboy_taken_i(attaboy_taken_i), .attaboy_ghist_i(attaboy_ghist_i),
    .if1_we_i(if1_we_i), .if2_we_i(if2_we_i),
    .btb_hit_i(btb_hit), .btb_tgt_i(btb_tgt), .bht_pred_i(bht_pred),
    .btb_init_done_i(btb_init_done), .bht_init_done_i(bht_init_done),
    .next_pc_o(next_pc_o), .rd_v_o(rd_v), .rd_ghist_o(rd_ghist),
    .btb_w_v_o(btb_w_v), .btb_w_clr_o(btb_w_clr),
    .btb_w_addr_o(btb_w_addr), .btb_w_tgt_o(btb_w_tgt),
    .bht_w_v_o(bht_w_v), .bht_w_addr_o(bht_w_addr),
    .bht_w_ghist_o(bht_w_ghist), .bht_w_taken_o(bht_w_taken),
    .if2_pc_o(if2_pc_o), .if2_pred_taken_o(if2_pred_taken_o), .if2_ghist_o(if2_ghist_o),
    .attaboy_yumi_o(attaboy_yumi_o), .init_done_o(init_done_o)
  );

endmodule

`default_nettype wire

// ==== logic/fe_pc_select.sv ====
// Next-PC selection and training
`timescale 1ns/1ps
`default_nettype none

module fe_pc_select (
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire            redirect_v_i,
  input  fe_pkg::vaddr_t redirect_pc_i,
  input  wire            redirect_br_v_i,
  input  fe_pkg::vaddr_t redirect_br_pc_i,
  input  wire            redirect_br_taken_i,
  input  fe_pkg::ghist_t redirect_br_ghist_i,
  input  wire            attaboy_v_i,
  input  fe_pkg::vaddr_t attaboy_pc_i,
  input  fe_pkg::vaddr_t attaboy_tgt_i,
  input  wire            attaboy_taken_i,
  input  fe_pkg::ghist_t attaboy_ghist_i,
  input  wire            if1_we_i,
  input  wire            if2_we_i,
  input  wire            btb_hit_i,
  input  fe_pkg::vaddr_t btb_tgt_i,
  input  wire            bht_pred_i,
  input  wire            btb_init_done_i,
  input  wire            bht_init_done_i,
  output fe_pkg::vaddr_t next_pc_o,
  output logic           rd_v_o,
  output fe_pkg::ghist_t rd_ghist_o,
  output logic           btb_w_v_o,
  output logic           btb_w_clr_o,
  output fe_pkg::vaddr_t btb_w_addr_o,
  output fe_pkg::vaddr_t btb_w_tgt_o,
  output logic           bht_w_v_o,
  output fe_pkg::vaddr_t bht_w_addr_o,
  output fe_pkg::ghist_t bht_w_ghist_o,
  output logic           bht_w_taken_o,
  output fe_pkg::vaddr_t if2_pc_o,
  output logic           if2_pred_taken_o,
  output fe_pkg::ghist_t if2_ghist_o,
  output logic           attaboy_yumi_o,
  output logic           init_done_o
);

  fe_pkg::vaddr_t if1_pc_r;
  logic           if1_looked_r;
  fe_pkg::ghist_t if1_ghist_r;
  logic           if1_taken;
  fe_pkg::ghist_t ghist_r;
  fe_pkg::ghist_t ghist_n;
  logic           br_train;

  //////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////
  // Boot entry in IF1 carries no lookup
  assign if1_taken = if1_looked_r && btb_hit_i && bht_pred_i;

  always_comb
  begin
    if (redirect_v_i)
      next_pc_o = redirect_pc_i;
    else if (if1_taken)
      next_pc_o = btb_tgt_i;
    else
      next_pc_o = if1_pc_r + fe_pkg::vaddr_t'(4);
  end

  // Resolved branch restores history, else IF1 outcome shifts in
  always_comb
  begin
    if (redirect_br_v_i)
      ghist_n = {redirect_br_ghist_i[fe_pkg::ghist_width-2:0], redirect_br_taken_i};
    else if (if1_we_i && if1_looked_r)
      ghist_n = {ghist_r[fe_pkg::ghist_width-2:0], if1_taken};
    else
      ghist_n = ghist_r;
  end

  assign rd_v_o     = if1_we_i;
  assign rd_ghist_o = ghist_n;

  //////////////////////////////////////////////////
  // Stage registers and history
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      if1_pc_r     <= fe_pkg::boot_pc - fe_pkg::vaddr_t'(4);
      if1_looked_r <= 1'b0;
      if1_ghist_r  <= '0;
      ghist_r      <= '0;
    end
    else
    begin
      ghist_r <= ghist_n;
      if (if1_we_i)
      begin
        if1_pc_r     <= next_pc_o;
        if1_looked_r <= 1'b1;
        if1_ghist_r  <= ghist_n;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      if2_pc_o         <= '0;
      if2_pred_taken_o <= 1'b0;
      if2_ghist_o      <= '0;
    end
    else if (if2_we_i)
    begin
      if2_pc_o         <= if1_pc_r;
      if2_pred_taken_o <= if1_taken;
      if2_ghist_o      <= if1_ghist_r;
    end
  end

  //////////////////////////////////////////////////
  // Training arbitration
  //////////////////////////////////////////////////
  assign init_done_o    = btb_init_done_i && bht_init_done_i;
  assign br_train       = redirect_br_v_i && init_done_o;
  assign attaboy_yumi_o = attaboy_v_i && !redirect_br_v_i && init_done_o;

  // Not-taken resolution invalidates the entry
  assign btb_w_v_o    = br_train || (attaboy_yumi_o && attaboy_taken_i);
  assign btb_w_clr_o  = br_train && !redirect_br_taken_i;
  assign btb_w_addr_o = br_train ? redirect_br_pc_i : attaboy_pc_i;
  assign btb_w_tgt_o  = br_train ? redirect_pc_i : attaboy_tgt_i;

  assign bht_w_v_o     = br_train || attaboy_yumi_o;
  assign bht_w_addr_o  = br_train ? redirect_br_pc_i : attaboy_pc_i;
  assign bht_w_ghist_o = br_train ? redirect_br_ghist_i : attaboy_ghist_i;
  assign bht_w_taken_o = br_train ? redirect_br_taken_i : attaboy_taken_i;

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    attaboy_yumi_o |-> attaboy_v_i);

endmodule

`default_nettype wire

// ==== logic/fe_pkg.sv ====
// Fetch next-PC definitions
`default_nettype none

package fe_pkg;

  //////////////////////////////////////////////////
  // Address and history widths
  //////////////////////////////////////////////////
  localparam int vaddr_width   = 32;
  localparam int ghist_width   = 2;
  localparam int start_bit     = 2;

  // Table geometry
  localparam int btb_idx_width = 4;
  localparam int btb_tag_width = 8;
  localparam int btb_entries   = 1 << btb_idx_width;
  localparam int bht_idx_width = 6;
  localparam int bht_entries   = 1 << bht_idx_width;

  typedef logic [vaddr_width-1:0]   vaddr_t;
  typedef logic [btb_idx_width-1:0] btb_idx_t;
  typedef logic [btb_tag_width-1:0] btb_tag_t;
  typedef logic [bht_idx_width-1:0] bht_idx_t;
  typedef logic [ghist_width-1:0]   ghist_t;
  typedef logic [1:0]               ctr_t;

  // Counter starts weakly not taken
  localparam ctr_t   ctr_weak_nt = 2'b01;
  localparam vaddr_t boot_pc     = 32'h0000_1000;

  // Table init sequencing
  typedef enum logic {
    init_sweep,
    init_ready
  } init_state_e;

endpackage

`default_nettype wire

// ==== verif/tb_fe_pc_gen.sv ====
// Next-PC generator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fe_pc_gen;

  typedef struct packed {
    logic           rv;
    fe_pkg::vaddr_t rpc;
    logic           bv;
    fe_pkg::vaddr_t bpc;
    logic           bt;
    fe_pkg::ghist_t bg;
    logic           av;
    fe_pkg::vaddr_t apc;
    fe_pkg::vaddr_t atgt;
    logic           at;
    fe_pkg::ghist_t ag;
    logic           w1;
    logic           w2;
    fe_pkg::vaddr_t exp_next;
    fe_pkg::vaddr_t exp_if2_pc;
    logic           exp_if2_taken;
    fe_pkg::ghist_t exp_if2_ghist;
    logic           exp_yumi;
  } row_t;

  localparam fe_pkg::vaddr_t br_pc   = 32'h0000_2040;
  localparam fe_pkg::vaddr_t br_tgt  = 32'h0000_3000;
  localparam fe_pkg::vaddr_t ab_pc   = 32'h0000_2468;
  localparam fe_pkg::vaddr_t ab_tgt  = 32'h0000_2800;
  localparam int             init_timeout = 200;

  logic clk_i;
  logic arst_n_i;
  logic redirect_v_i, redirect_br_v_i, redirect_br_taken_i;
  logic attaboy_v_i, attaboy_taken_i, if1_we_i, if2_we_i;
  fe_pkg::vaddr_t redirect_pc_i, redirect_br_pc_i, attaboy_pc_i, attaboy_tgt_i;
  fe_pkg::ghist_t redirect_br_ghist_i, attaboy_ghist_i;
  fe_pkg::vaddr_t next_pc_o, if2_pc_o;
  fe_pkg::ghist_t if2_ghist_o;
  logic if2_pred_taken_o, attaboy_yumi_o, init_done_o;

  // Reference model state
  fe_pkg::vaddr_t   m_if1_pc, m_tgt, m_if2_pc;
  fe_pkg::ghist_t   m_ghist, m_if1_ghist, m_if2_ghist;
  logic             m_looked, m_hit, m_pred, m_if2_taken;
  logic             m_valid [16];
  fe_pkg::btb_tag_t m_tag [16];
  fe_pkg::vaddr_t   m_tgt_mem [16];
  fe_pkg::ctr_t     m_ctr [64];

  row_t        rows [0:255];
  int          n_rows;
  logic [31:0] seed;

  fe_pc_gen uut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .redirect_v_i(redirect_v_i), .redirect_pc_i(redirect_pc_i),
    .redirect_br_v_i(redirect_br_v_i), .redirect_br_pc_i(redirect_br_pc_i),
    .redirect_br_taken_i(redirect_br_taken_i), .redirect_br_ghist_i(redirect_br_ghist_i),
    .attaboy_v_i(attaboy_v_i), .attaboy_pc_i(attaboy_pc_i), .attaboy_tgt_i(attaboy_tgt_i),
    .attaboy_taken_i(attaboy_taken_i), .attaboy_ghist_i(attaboy_ghist_i),
    .if1_we_i(if1_we_i), .if2_we_i(if2_we_i),
    .next_pc_o(next_pc_o), .if2_pc_o(if2_pc_o), .if2_pred_taken_o(if2_pred_taken_o),
    .if2_ghist_o(if2_ghist_o), .attaboy_yumi_o(attaboy_yumi_o), .init_done_o(init_done_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_vaddr(input string name, input fe_pkg::vaddr_t got,
                             input fe_pkg::vaddr_t exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_ghist(input string name, input fe_pkg::ghist_t got,
                             input fe_pkg::ghist_t exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "history mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Address bits 7..6 folded with history, bits 5..2 as is
  function automatic fe_pkg::bht_idx_t gshare_idx(input fe_pkg::vaddr_t pc,
                                                  input fe_pkg::ghist_t h);
    return {pc[7:6] ^ h, pc[5:2]};
  endfunction

  function automatic logic if1_pred();
    return m_looked && m_hit && m_pred;
  endfunction

  // History seen by a lookup on the next IF1 advance
  function automatic fe_pkg::ghist_t adv_hist();
    return m_looked ? {m_ghist[0], if1_pred()} : m_ghist;
  endfunction

  function automatic row_t idle_row(input logic w1, input logic w2);
    row_t r;
    r    = '0;
    r.w1 = w1;
    r.w2 = w2;
    return r;
  endfunction

  task automatic train_model(input fe_pkg::vaddr_t pc, input logic taken,
                             input fe_pkg::ghist_t h, input fe_pkg::vaddr_t tgt,
                             input logic btb_we);
    fe_pkg::bht_idx_t ix;
    ix = gshare_idx(pc, h);
    if (btb_we)
    begin
      m_valid[pc[5:2]] = taken;
      if (taken)
      begin
        m_tag[pc[5:2]]     = pc[13:6];
        m_tgt_mem[pc[5:2]] = tgt;
      end
    end
    if (taken && m_ctr[ix] != 2'b11)
      m_ctr[ix] = m_ctr[ix] + 2'd1;
    else if (!taken && m_ctr[ix] != 2'b00)
      m_ctr[ix] = m_ctr[ix] - 2'd1;
  endtask

  // Fills expected values from the state before the edge, then steps the model
  task automatic add_row(input row_t r);
    logic           tk;
    fe_pkg::ghist_t gn;
    tk              = if1_pred();
    r.exp_next      = r.rv ? r.rpc : (tk ? m_tgt : m_if1_pc + 32'd4);
    r.exp_if2_pc    = m_if2_pc;
    r.exp_if2_taken = m_if2_taken;
    r.exp_if2_ghist = m_if2_ghist;
    r.exp_yumi      = r.av && !r.bv;
    gn = r.bv ? {r.bg[0], r.bt} : ((r.w1 && m_looked) ? {m_ghist[0], tk} : m_ghist);
    if (r.w1)
    begin
      m_hit  = m_valid[r.exp_next[5:2]] && (m_tag[r.exp_next[5:2]] == r.exp_next[13:6]);
      m_tgt  = m_tgt_mem[r.exp_next[5:2]];
      m_pred = m_ctr[gshare_idx(r.exp_next, gn)][1];
    end
    if (r.w2)
    begin
      m_if2_pc    = m_if1_pc;
      m_if2_taken = tk;
      m_if2_ghist = m_if1_ghist;
    end
    if (r.w1)
    begin
      m_if1_pc    = r.exp_next;
      m_looked    = 1'b1;
      m_if1_ghist = gn;
    end
    m_ghist = gn;
    if (r.bv)
      train_model(r.bpc, r.bt, r.bg, r.rpc, 1'b1);
    else if (r.av)
      train_model(r.apc, r.at, r.ag, r.atgt, r.at);
    rows[n_rows] = r;
    n_rows++;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////
  task automatic build_table();
    row_t           r;
    fe_pkg::ghist_t g;
    int             i;
    m_if1_pc = fe_pkg::boot_pc - 32'd4;
    {m_looked, m_hit, m_pred, m_if2_taken} = '0;
    {m_tgt, m_if2_pc, m_ghist, m_if1_ghist, m_if2_ghist} = '0;
    for (i = 0; i < 64; i++)
    begin
      m_ctr[i] = fe_pkg::ctr_weak_nt;
      if (i < 16)
      begin
        m_valid[i]   = 1'b0;
        m_tag[i]     = '0;
        m_tgt_mem[i] = '0;
      end
    end
    n_rows = 0;
    // Sequential fetch with stalls on either stage
    for (i = 0; i < 6; i++)
      add_row(idle_row(1'b1, i > 1));
    add_row(idle_row(1'b0, 1'b0));
    add_row(idle_row(1'b0, 1'b1));
    add_row(idle_row(1'b1, 1'b1));
    r = idle_row(1'b1, 1'b1);
    r.rv  = 1'b1;
    r.rpc = 32'h0000_2400;
    add_row(r);
    for (i = 0; i < 3; i++)
      add_row(idle_row(1'b1, 1'b1));
    // Two taken resolutions from a clear history
    // Two untaken advances shift the taken bit out before P is fetched
    g = 2'b00;
    for (i = 0; i < 2; i++)
    begin
      r = idle_row(1'b0, 1'b0);
      {r.bv, r.bpc, r.bt, r.bg, r.rpc} = {1'b1, br_pc, 1'b1, g, br_tgt};
      add_row(r);
    end
    add_row(idle_row(1'b1, 1'b1));
    r = idle_row(1'b1, 1'b1);
    {r.rv, r.rpc} = {1'b1, br_pc};
    add_row(r);
    for (i = 0; i < 3; i++)
      add_row(idle_row(1'b1, 1'b1));
    // Not-taken resolution drops the entry
    r = idle_row(1'b1, 1'b1);
    {r.rv, r.rpc, r.bv, r.bpc, r.bt, r.bg} = {1'b1, br_pc + 32'd4, 1'b1, br_pc, 1'b0, g};
    add_row(r);
    add_row(idle_row(1'b1, 1'b1));
    r = idle_row(1'b1, 1'b1);
    {r.rv, r.rpc} = {1'b1, br_pc};
    add_row(r);
    for (i = 0; i < 3; i++)
      add_row(idle_row(1'b1, 1'b1));
    // Attaboy blocked by a resolution, then accepted twice
    r = idle_row(1'b0, 1'b0);
    {r.av, r.apc, r.atgt, r.at} = {1'b1, ab_pc, ab_tgt, 1'b1};
    {r.bv, r.bpc, r.bt, r.bg} = {1'b1, 32'h0000_2104, 1'b0, 2'b00};
    add_row(r);
    g = adv_hist();
    for (i = 0; i < 2; i++)
    begin
      r = idle_row(1'b0, 1'b0);
      {r.av, r.apc, r.atgt, r.at, r.ag} = {1'b1, ab_pc, ab_tgt, 1'b1, g};
      add_row(r);
    end
    r = idle_row(1'b1, 1'b1);
    {r.rv, r.rpc} = {1'b1, ab_pc};
    add_row(r);
    for (i = 0; i < 3; i++)
      add_row(idle_row(1'b1, 1'b1));
    // Mixed random traffic in a small address window
    for (i = 0; i < 60; i++)
    begin
      seed = lcg_step(seed);
      r = idle_row(seed[31] | seed[30], seed[29] | seed[28]);
      r.rv = (seed[27:25] == 3'd0);
      r.bv = seed[24] & seed[23];
      {r.bt, r.bg, r.av, r.at, r.ag} = seed[22:16];
      seed = lcg_step(seed);
      r.rpc  = 32'h0000_2000 | {24'd0, seed[31:26], 2'b00};
      r.bpc  = 32'h0000_2000 | {24'd0, seed[25:20], 2'b00};
      r.apc  = 32'h0000_2000 | {24'd0, seed[19:14], 2'b00};
      r.atgt = 32'h0000_2000 | {24'd0, seed[13:8], 2'b00};
      add_row(r);
    end
    for (i = 0; i < 3; i++)
      add_row(idle_row(1'b1, 1'b1));
  endtask

  task automatic drive_row(input row_t r);
    {redirect_v_i, redirect_pc_i} = {r.rv, r.rpc};
    {redirect_br_v_i, redirect_br_pc_i} = {r.bv, r.bpc};
    {redirect_br_taken_i, redirect_br_ghist_i} = {r.bt, r.bg};
    {attaboy_v_i, attaboy_pc_i, attaboy_tgt_i} = {r.av, r.apc, r.atgt};
    {attaboy_taken_i, attaboy_ghist_i} = {r.at, r.ag};
    {if1_we_i, if2_we_i} = {r.w1, r.w2};
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    int i;
    int cnt;
    arst_n_i = 1'b0;
    seed     = 32'h5218f178;
    drive_row(idle_row(1'b0, 1'b0));
    build_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_vaddr("next_pc_o", next_pc_o, fe_pkg::boot_pc);
    check_bit("init_done_o", init_done_o, 1'b0);
    arst_n_i = 1'b1;
    #10;
    check_bit("init_done_o", init_done_o, 1'b0);
    cnt = 0;
    while (init_done_o !== 1'b1)
    begin
      if (cnt >= init_timeout)
      begin
        $display("init_done_o did not rise within %0d cycles after reset", init_timeout);
        $display("TB FAILED");
        $fatal(1, "init timeout");
      end
      else
      begin
        @(negedge clk_i);
        cnt++;
      end
    end
    check_vaddr("next_pc_o", next_pc_o, fe_pkg::boot_pc);
    for (i = 0; i < n_rows; i++)
    begin
      @(negedge clk_i);
      drive_row(rows[i]);
      #10;
      check_vaddr("next_pc_o", next_pc_o, rows[i].exp_next);
      check_vaddr("if2_pc_o", if2_pc_o, rows[i].exp_if2_pc);
      check_bit("if2_pred_taken_o", if2_pred_taken_o, rows[i].exp_if2_taken);
      check_ghist("if2_ghist_o", if2_ghist_o, rows[i].exp_if2_ghist);
      check_bit("attaboy_yumi_o", attaboy_yumi_o, rows[i].exp_yumi);
      check_bit("init_done_o", init_done_o, 1'b1);
    end
    @(negedge clk_i);
    drive_row(idle_row(1'b0, 1'b0));
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
